/* src/mul_op_pkg.sv */
`default_nettype none

package mul_op_pkg;

  // width of the sec64 scale factor
  localparam int scale_w = 12;

  // codes 9 to 15 decode as mul64
  typedef enum logic [3:0] {
    mul64     = 4'd0,
    imul64    = 4'd1,
    lmul64    = 4'd2,
    limul64   = 4'd3,
    mul32     = 4'd4,
    imul32    = 4'd5,
    mul32_64  = 4'd6,
    imul32_64 = 4'd7,
    sec64     = 4'd8
  } mul_op_e;

  // control bits that follow an operation down the pipe
  typedef struct packed {
    logic valid;
    logic a_signed;
    logic b_signed;
    // 32-bit operand forms
    logic width32;
    // result is the low 32 bits, zero-extended
    logic res32;
    logic take_high;
    logic scaled;
  } mul_ctl_t;

endpackage

`default_nettype wire

/* src/mul_res_pkg.sv */
`default_nettype none

package mul_res_pkg;

  // issue edge to result edge, in enabled cycles
  localparam int mul_latency = 4;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mul_half_t;

  // one 64-bit result word, seen whole or as two halves
  typedef union packed {
    logic [63:0] word;
    mul_half_t   half;
  } mul_word_u;

  // cf sits in bit 5, pf in bit 0
  typedef struct packed {
    logic cf;
    logic of;
    logic rsv;
    logic sf;
    logic zf;
    logic pf;
  } mul_flags_t;

endpackage

`default_nettype wire

/* src/mul_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_decode
  import mul_op_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clk_en,
  input  logic        en,
  input  mul_op_e     op,
  input  logic [64:0] a,
  input  logic [64:0] b,
  output mul_ctl_t    ctl,
  output logic [64:0] a_ext,
  output logic [64:0] b_ext
);

  mul_ctl_t ctl_d;

  // sign or zero fill to 65 bits; the tag bit is dropped here
  function automatic logic [64:0] extend(input logic [64:0] v, input logic sgn,
                                         input logic w32);
    logic [64:0] ext;
    if (w32) begin
      ext = {{33{sgn & v[31]}}, v[31:0]};
    end else begin
      ext = {sgn & v[63], v[63:0]};
    end
    return ext;
  endfunction

  always_comb begin
    ctl_d = '0;
    ctl_d.valid = en;
    case (op)
      imul64: begin
        ctl_d.a_signed = 1'b1;
        ctl_d.b_signed = 1'b1;
      end
      lmul64: ctl_d.take_high = 1'b1;
      limul64: begin
        ctl_d.a_signed  = 1'b1;
        ctl_d.b_signed  = 1'b1;
        ctl_d.take_high = 1'b1;
      end
      mul32: begin
        ctl_d.width32 = 1'b1;
        ctl_d.res32   = 1'b1;
      end
      imul32: begin
        ctl_d.a_signed = 1'b1;
        ctl_d.b_signed = 1'b1;
        ctl_d.width32  = 1'b1;
        ctl_d.res32    = 1'b1;
      end
      mul32_64: ctl_d.width32 = 1'b1;
      imul32_64: begin
        ctl_d.a_signed = 1'b1;
        ctl_d.b_signed = 1'b1;
        ctl_d.width32  = 1'b1;
      end
      sec64: ctl_d.scaled = 1'b1;
      default: ;
    endcase
    // bubbles carry no mode bits
    if (!en) begin
      ctl_d = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl <= '0;
    end else if (clk_en) begin
      ctl <= ctl_d;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      a_ext <= extend(a, ctl_d.a_signed, ctl_d.width32);
      b_ext <= extend(b, ctl_d.b_signed, ctl_d.width32);
    end
  end

endmodule

`default_nettype wire

/* src/mul_array.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_array
  import mul_op_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clk_en,
  input  mul_ctl_t     ctl_in,
  input  logic [64:0]  a_ext,
  input  logic [64:0]  b_ext,
  output mul_ctl_t     ctl_out,
  output logic [127:0] product
);

  // signed upper parts, unsigned lower parts
  logic signed [32:0] a_hi;
  logic signed [32:0] b_hi;
  logic        [31:0] a_lo;
  logic        [31:0] b_lo;

  logic signed [65:0] pp_hh;
  logic signed [65:0] pp_hl;
  logic signed [65:0] pp_lh;
  logic        [63:0] pp_ll;

  logic signed [65:0] pp_hh_r;
  logic signed [65:0] pp_hl_r;
  logic signed [65:0] pp_lh_r;
  logic        [63:0] pp_ll_r;
  mul_ctl_t           ctl_r;

  logic [127:0] sum;

  assign a_hi = a_ext[64:32];
  assign b_hi = b_ext[64:32];
  assign a_lo = a_ext[31:0];
  assign b_lo = b_ext[31:0];

  // cross products, lower halves widened to stay non-negative
  assign pp_hh = a_hi * b_hi;
  assign pp_hl = a_hi * $signed({1'b0, b_lo});
  assign pp_lh = $signed({1'b0, a_lo}) * b_hi;
  assign pp_ll = a_lo * b_lo;

  // only the low 64 bits of hh land inside 128 bits
  assign sum = {pp_hh_r[63:0], 64'b0}
             + {{30{pp_hl_r[65]}}, pp_hl_r, 32'b0}
             + {{30{pp_lh_r[65]}}, pp_lh_r, 32'b0}
             + {64'b0, pp_ll_r};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl_r   <= '0;
      ctl_out <= '0;
    end else if (clk_en) begin
      ctl_r   <= ctl_in;
      ctl_out <= ctl_r;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      pp_hh_r <= pp_hh;
      pp_hl_r <= pp_hl;
      pp_lh_r <= pp_lh;
      pp_ll_r <= pp_ll;
      product <= sum;
    end
  end

endmodule

`default_nettype wire

/* src/scaled_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module scaled_mul
  import mul_op_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               clk_en,
  input  logic               en,
  input  logic [64:0]        a,
  input  logic [scale_w-1:0] scale,
  output logic [64:0]        scaled
);

  logic [63:0] part [scale_w];
  logic [63:0] sum_lo;
  logic [63:0] sum_hi;
  logic [63:0] sum_lo_r;
  logic [63:0] sum_hi_r;
  logic [64:0] total_r;
  logic        tag_r;
  logic        v1;
  logic        v2;

  always_comb begin
    for (int i = 0; i < scale_w; i++) begin
      part[i] = scale[i] ? a[63:0] << i : 64'b0;
    end
    sum_lo = '0;
    sum_hi = '0;
    for (int i = 0; i < scale_w / 2; i++) begin
      sum_lo = sum_lo + part[i];
      sum_hi = sum_hi + part[i + scale_w / 2];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else if (clk_en) begin
      v1 <= en;
      v2 <= v1;
    end
  end

  // stages only move when they hold an issued operation
  always_ff @(posedge clk) begin
    if (clk_en && en) begin
      sum_lo_r <= sum_lo;
      sum_hi_r <= sum_hi;
      tag_r    <= a[64];
    end
    if (clk_en && v1) begin
      total_r <= {tag_r, sum_lo_r + sum_hi_r};
    end
    // extra stage lines up with decode plus array
    if (clk_en && v2) begin
      scaled <= total_r;
    end
  end

endmodule

`default_nettype wire

/* src/mul_result.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_result
  import mul_op_pkg::*;
  import mul_res_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         clk_en,
  input  mul_ctl_t     ctl,
  input  logic [127:0] product,
  input  logic [64:0]  scaled,
  output logic [64:0]  res,
  output mul_flags_t   flags,
  output logic         res_valid
);

  mul_word_u  lo_w;
  mul_word_u  hi_w;
  mul_word_u  sel_w;
  logic       tag;
  logic       ovf;
  mul_flags_t flags_d;

  assign lo_w.word = product[63:0];
  assign hi_w.word = product[127:64];

  always_comb begin
    tag = 1'b0;
    if (ctl.scaled) begin
      sel_w.word = scaled[63:0];
      tag        = scaled[64];
      ovf        = 1'b0;
    end else if (ctl.res32) begin
      sel_w.half.hi = '0;
      sel_w.half.lo = lo_w.half.lo;
      if (ctl.a_signed) begin
        ovf = lo_w.half.hi != {32{lo_w.half.lo[31]}};
      end else begin
        ovf = lo_w.half.hi != '0;
      end
    end else if (ctl.width32) begin
      // 32x32 into 64 bits, fits unless the top half is not bit 31 repeated
      sel_w.word = lo_w.word;
      ovf        = lo_w.half.hi != {32{lo_w.half.lo[31]}};
    end else begin
      sel_w.word = ctl.take_high ? hi_w.word : lo_w.word;
      if (ctl.a_signed) begin
        ovf = hi_w.word != {64{lo_w.word[63]}};
      end else begin
        ovf = hi_w.word != '0;
      end
    end

    flags_d.cf  = ovf;
    flags_d.of  = ovf;
    flags_d.rsv = 1'b0;
    flags_d.sf  = ctl.res32 ? sel_w.half.lo[31] : sel_w.word[63];
    flags_d.zf  = sel_w.word == '0;
    // even parity on the low byte
    flags_d.pf  = ~^sel_w.word[7:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      flags     <= '0;
      res_valid <= 1'b0;
    end else if (clk_en) begin
      res_valid <= ctl.valid;
      // result bus keeps the last result between issues
      if (ctl.valid) begin
        res   <= {tag, sel_w.word};
        flags <= flags_d;
      end
    end
  end

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit
  import mul_op_pkg::*;
  import mul_res_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        clk_en,
  input  logic        en,
  input  mul_op_e     op,
  input  logic [64:0] a,
  input  logic [64:0] b,
  output logic [64:0] res,
  output mul_flags_t  flags,
  output logic        res_valid
);

  mul_ctl_t     dec_ctl;
  mul_ctl_t     arr_ctl;
  logic [64:0]  a_ext;
  logic [64:0]  b_ext;
  logic [127:0] product;
  logic [64:0]  scaled;

  mul_decode i_decode (
    .clk    (clk),
    .arst_n (arst_n),
    .clk_en (clk_en),
    .en     (en),
    .op     (op),
    .a      (a),
    .b      (b),
    .ctl    (dec_ctl),
    .a_ext  (a_ext),
    .b_ext  (b_ext)
  );

  mul_array i_array (
    .clk     (clk),
    .arst_n  (arst_n),
    .clk_en  (clk_en),
    .ctl_in  (dec_ctl),
    .a_ext   (a_ext),
    .b_ext   (b_ext),
    .ctl_out (arr_ctl),
    .product (product)
  );

  // raw a keeps its tag bit; three stages match decode plus array
  scaled_mul i_scaled (
    .clk    (clk),
    .arst_n (arst_n),
    .clk_en (clk_en),
    .en     (en),
    .a      (a),
    .scale  (b[scale_w-1:0]),
    .scaled (scaled)
  );

  mul_result i_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .clk_en    (clk_en),
    .ctl       (arr_ctl),
    .product   (product),
    .scaled    (scaled),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

endmodule

`default_nettype wire

/* tb/mul_unit_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_assert
  import mul_res_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        clk_en,
  input logic [64:0] res,
  input mul_flags_t  flags,
  input logic        res_valid
);

  // reserved flag bit
  rsv_zero: assert property (@(posedge clk) disable iff (!arst_n) flags[3] == 1'b0)
    else $error("reserved flag bit is set");

  hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
    !clk_en |=> $stable(res) && $stable(flags) && $stable(res_valid))
    else $error("outputs changed while clk_en was low");

  quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !res_valid)
    else $error("res_valid high during reset");

  valid_known: assert property (@(posedge clk) !$isunknown(res_valid))
    else $error("res_valid is unknown");

endmodule

bind mul_unit mul_unit_assert i_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .clk_en    (clk_en),
  .res       (res),
  .flags     (flags),
  .res_valid (res_valid)
);

`default_nettype wire

/* tb/mul_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb
  import mul_op_pkg::*;
  import mul_res_pkg::*;
();

  typedef struct packed {
    logic [64:0] res;
    mul_flags_t  flags;
    logic [31:0] issue;
  } expect_t;

  logic        clk;
  logic        arst_n;
  logic        clk_en;
  logic        en;
  mul_op_e     op;
  logic [64:0] a;
  logic [64:0] b;
  logic [64:0] res;
  mul_flags_t  flags;
  logic        res_valid;

  expect_t pending [$];
  int      edge_cnt;
  int      errors;
  int      checks;
  int      tests;

  mul_unit i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .clk_en    (clk_en),
    .en        (en),
    .op        (op),
    .a         (a),
    .b         (b),
    .res       (res),
    .flags     (flags),
    .res_valid (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string name, input logic [127:0] got,
                       input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // expected result and flags, straight from the operation rules
  function automatic expect_t model(input logic [3:0] code, input logic [64:0] x,
                                    input logic [64:0] y);
    expect_t      e;
    logic [127:0] p;
    mul_word_u    w;
    logic         ovf;
    e   = '0;
    ovf = 1'b0;
    case (code)
      4'd1, 4'd3: begin
        p      = {{64{x[63]}}, x[63:0]} * {{64{y[63]}}, y[63:0]};
        ovf    = p[127:64] != {64{p[63]}};
        w.word = (code == 4'd3) ? p[127:64] : p[63:0];
      end
      4'd4, 4'd5, 4'd6, 4'd7: begin
        if (code[0]) begin
          p = {{96{x[31]}}, x[31:0]} * {{96{y[31]}}, y[31:0]};
        end else begin
          p = {96'b0, x[31:0]} * {96'b0, y[31:0]};
        end
        w.word = p[63:0];
        if (code == 4'd4) begin
          ovf = w.half.hi != '0;
        end else begin
          ovf = w.half.hi != {32{w.half.lo[31]}};
        end
        // mul32 and imul32 return only the low half
        if (!code[1]) begin
          w.half.hi = '0;
        end
      end
      4'd8: begin
        p         = {64'b0, x[63:0]} * {116'b0, y[11:0]};
        w.word    = p[63:0];
        e.res[64] = x[64];
      end
      default: begin
        p      = {64'b0, x[63:0]} * {64'b0, y[63:0]};
        ovf    = p[127:64] != '0;
        w.word = (code == 4'd2) ? p[127:64] : p[63:0];
      end
    endcase
    e.res[63:0]  = w.word;
    e.flags.cf   = ovf;
    e.flags.of   = ovf;
    e.flags.rsv  = 1'b0;
    e.flags.sf   = (code == 4'd4 || code == 4'd5) ? w.half.lo[31] : w.word[63];
    e.flags.zf   = w.word == '0;
    e.flags.pf   = ~^w.word[7:0];
    return e;
  endfunction

  // runs 2 ns after an edge, inputs of that edge still applied
  task automatic sample_outputs();
    expect_t e;
    if (clk_en) begin
      edge_cnt++;
      if (res_valid) begin
        if (pending.size() == 0) begin
          $display("result valid at edge %0d with nothing in flight", edge_cnt);
          errors++;
        end else begin
          e = pending.pop_front();
          check("res", res, e.res);
          check("flags", flags, e.flags);
          // consumed at the next enabled edge
          check("latency", edge_cnt + 1 - e.issue, mul_latency);
        end
      end
      if (en) begin
        e       = model(op, a, b);
        e.issue = edge_cnt;
        pending.push_back(e);
      end
    end
  endtask

  task automatic cycle(input logic v, input mul_op_e o, input logic [64:0] x,
                       input logic [64:0] y, input logic ce);
    @(posedge clk);
    #2;
    sample_outputs();
    en     = v;
    op     = o;
    a      = x;
    b      = y;
    clk_en = ce;
  endtask

  function automatic logic [64:0] rand65();
    logic [95:0] r;
    r = {$urandom(), $urandom(), $urandom()};
    return r[64:0];
  endfunction

  // all ones, minimum negative, or left as drawn
  function automatic logic [64:0] pick_extreme(input logic [64:0] v);
    case ($urandom() % 3)
      0: return {v[64], {64{1'b1}}};
      1: return {v[64], 1'b1, 63'b0};
      default: return v;
    endcase
  endfunction

  task automatic drain();
    int waited;
    waited = 0;
    do begin
      cycle(1'b0, mul64, '0, '0, 1'b1);
      waited++;
    end while (pending.size() != 0 && waited < 50);
    if (pending.size() != 0) begin
      $display("timeout with %0d results still outstanding", pending.size());
      errors++;
      pending.delete();
    end
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int          err0;
    int          chk0;
    logic [3:0]  code;
    logic [64:0] x;
    logic [64:0] y;
    logic        v;
    logic        ce;
    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < n; i++) begin
      x  = rand65();
      y  = rand65();
      v  = ($urandom() % 10) < 7;
      ce = ($urandom() % 10) < 8;
      case (kind)
        1: code = 4'($urandom() % 2);
        2: begin
          code = 4'd2 + 4'($urandom() % 2);
          x    = pick_extreme(x);
          y    = pick_extreme(y);
        end
        3: code = 4'd4 + 4'($urandom() % 4);
        4: code = 4'd8;
        // back to back, unused codes included
        5: begin
          code = 4'($urandom() % 16);
          v    = 1'b1;
        end
        default: begin
          code = 4'($urandom() % 9);
          if ($urandom() % 3 == 0) begin
            x[63:0] = '0;
          end
        end
      endcase
      cycle(v, mul_op_e'(code), x, y, ce);
    end
    drain();
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  initial begin
    void'($urandom(32'hdf11));
    arst_n   = 1'b1;
    clk_en   = 1'b0;
    en       = 1'b0;
    op       = mul64;
    a        = '0;
    b        = '0;
    edge_cnt = 0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    #1;
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    run_test("low 64-bit forms", 1, 400);
    run_test("high-half forms", 2, 400);
    run_test("32-bit forms", 3, 400);
    run_test("scaled multiply", 4, 300);
    run_test("pipelining and stall", 5, 600);
    run_test("status flags", 6, 400);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
src/mul_op_pkg.sv
src/mul_res_pkg.sv
src/mul_decode.sv
src/mul_array.sv
src/scaled_mul.sv
src/mul_result.sv
src/mul_unit.sv
tb/mul_unit_assert.sv
tb/mul_unit_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := mul_unit_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then exit 1; fi
	@grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
